/* logic/mm_defines.svh */
// shared constants for the bus core; bases must sit on region-size boundaries
// MM_ROM_BANK must equal MM_SRAM_AW+1, MM_SRAM_WAIT must be at least 1
`ifndef MM_DEFINES_SVH
`define MM_DEFINES_SVH

// ------------------------------
// address map (byte addresses)
// ------------------------------
`define MM_CHIP_BASE    24'h000000  // 512K chip ram
`define MM_ROM_BASE     24'hF80000  // 512K kickstart
`define MM_CIA_BASE     24'hBF0000  // cia-a window
`define MM_RTC_BASE     24'hDC0000  // battery clock window

// ------------------------------
// external sram
// ------------------------------
`define MM_SRAM_AW      19          // word address bits per bank
`define MM_ROM_BANK     20          // upper sram address bit, 1 = rom bank
`define MM_SRAM_WAIT    2           // wait states per access

// ------------------------------
// system control
// ------------------------------
`define MM_RESET_FRAMES 4           // sof pulses in the reset stretch
`define MM_LED_DIM_LEN  16          // led period in hsync pulses

`endif

/* logic/mm_pkg.sv */
// bus, pin and decode types shared by all blocks
// request layout follows wishbone classic with a 16-bit data path
`include "mm_defines.svh"

package mm_pkg;

	// master request, held steady until ack
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [1:0]  sel;    // [1] upper byte, [0] lower byte
		logic [23:1] adr;    // word address
		logic [15:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;    // one cycle
		logic [15:0] dat;    // zero unless ack
	} wb_rsp_t;

	// sram control pins, data travels on separate ports
	typedef struct packed {
		logic [`MM_SRAM_AW+1:1] adr;  // top bit is the bank
		logic                   bhe_n;
		logic                   ble_n;
		logic                   we_n;
		logic                   oe_n;
	} sram_pins_t;

	// one-hot region select, all zero when no request
	typedef struct packed {
		logic chip;
		logic rom;
		logic cia;
		logic rtc;
		logic none;
	} region_t;

	// cpu word address, raw or split for cia register access
	typedef union packed {
		logic [23:1] raw;
		struct packed {
			logic [23:12] hi;
			logic [11:8]  cia_rs;  // cia register select
			logic [7:1]   lo;
		} f;
	} cpu_addr_u;

endpackage

/* logic/mm_bus_decode.sv */
// region decode, boot overlay and sram address forming
// acks rtc and unmapped accesses itself, one cycle, unmapped reads give zero
`timescale 1ns/1ps
`include "mm_defines.svh"

module mm_bus_decode (
	input  logic                   clk,
	input  logic                   rst_n,
	input  mm_pkg::wb_req_t        wb_req,
	input  logic                   ovl,
	input  logic [63:0]            rtc,
	output mm_pkg::region_t        region,
	output logic [`MM_SRAM_AW+1:1] sram_adr,
	output logic                   rom_wp,
	output mm_pkg::wb_rsp_t        rsp
);
	import mm_pkg::*;

	localparam logic [23:0] chip_base = `MM_CHIP_BASE;
	localparam logic [23:0] rom_base  = `MM_ROM_BASE;
	localparam logic [23:0] cia_base  = `MM_CIA_BASE;
	localparam logic [23:0] rtc_base  = `MM_RTC_BASE;

	cpu_addr_u            a;
	logic                 req;
	logic                 hit_chip, hit_rom, hit_cia, hit_rtc;
	logic                 bank;
	logic [`MM_SRAM_AW:1] ofs;
	logic                 ack_q;
	logic [3:0]           nib_q;

	assign a   = wb_req.adr;
	assign req = wb_req.cyc & wb_req.stb;

	// ------------------------------
	// region compare
	// ------------------------------
	assign hit_chip = a.raw[23:19] == chip_base[23:19];  // 512K
	assign hit_rom  = a.raw[23:19] == rom_base[23:19];   // 512K
	assign hit_cia  = a.raw[23:16] == cia_base[23:16];
	assign hit_rtc  = a.raw[23:16] == rtc_base[23:16];

	always_comb begin
		region.chip = req & hit_chip;
		region.rom  = req & hit_rom;
		region.cia  = req & hit_cia;
		region.rtc  = req & hit_rtc;
		region.none = req & ~(hit_chip | hit_rom | hit_cia | hit_rtc);
	end

	// overlay: chip reads go to the rom bank, writes still land in chip ram
	assign bank = hit_rom | (hit_chip & ovl & ~wb_req.we);

	// rom offset counted from its base so 0xf80000 hits bank word 0
	assign ofs = hit_rom ? a.raw[`MM_SRAM_AW:1] ^ rom_base[`MM_SRAM_AW:1]
		: a.raw[`MM_SRAM_AW:1];

	always_comb begin
		sram_adr = {1'b0, ofs};
		sram_adr[`MM_ROM_BANK] = bank;
	end

	assign rom_wp = region.rom & wb_req.we;  // kickstart is read only

	// ------------------------------
	// rtc / unmapped responder
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ack_q <= 1'b0;
		else
			ack_q <= (region.rtc | region.none) & ~ack_q;  // no re-ack on held stb
	end

	// nibble picked by address bits 5:2
	always_ff @(posedge clk) begin
		if (region.rtc && !wb_req.we)
			nib_q <= rtc[{a.f.lo[5:2], 2'b00} +: 4];
		else
			nib_q <= 4'h0;
	end

	always_comb begin
		rsp.ack = ack_q;
		rsp.dat = {12'h000, nib_q & {4{ack_q}}};
	end

endmodule

/* logic/mm_sram_bridge.sv */
// fixed latency cycle generator for one asynchronous 16-bit sram
// ack lands 1+MM_SRAM_WAIT edges after the request, read data sampled on that edge
`timescale 1ns/1ps
`include "mm_defines.svh"

module mm_sram_bridge (
	input  logic                   clk,
	input  logic                   rst_n,
	input  mm_pkg::wb_req_t        wb_req,
	input  logic                   sel_mem,
	input  logic                   rom_wp,
	input  logic [`MM_SRAM_AW+1:1] sram_adr,
	output mm_pkg::sram_pins_t     sram_pins,
	output logic [15:0]            sram_dq_out,
	input  logic [15:0]            sram_dq_in,
	output mm_pkg::wb_rsp_t        rsp
);
	import mm_pkg::*;

	localparam int cnt_w = $clog2(`MM_SRAM_WAIT + 1);

	typedef enum logic {
		st_idle,
		st_access
	} state_t;

	state_t           state;
	logic [cnt_w-1:0] cnt;
	logic             ack_q;
	logic [15:0]      rdat_q;
	logic             start;

	// new access only once the previous ack has gone
	assign start = sel_mem & ~ack_q;

	// ------------------------------
	// cycle fsm and pins
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state           <= st_idle;
			cnt             <= '0;
			ack_q           <= 1'b0;
			sram_pins.adr   <= '0;
			sram_pins.bhe_n <= 1'b1;
			sram_pins.ble_n <= 1'b1;
			sram_pins.we_n  <= 1'b1;
			sram_pins.oe_n  <= 1'b1;
		end else begin
			ack_q <= 1'b0;
			case (state)
				st_idle: begin
					if (start) begin
						state           <= st_access;
						cnt             <= cnt_w'(`MM_SRAM_WAIT);
						sram_pins.adr   <= sram_adr;
						sram_pins.bhe_n <= ~wb_req.sel[1];
						sram_pins.ble_n <= ~wb_req.sel[0];
						sram_pins.oe_n  <= wb_req.we;
						sram_pins.we_n  <= ~(wb_req.we & ~rom_wp);  // rom write swallowed
					end
				end
				st_access: begin
					cnt <= cnt - 1'b1;
					if (cnt == cnt_w'(1) || !sel_mem) begin
						state           <= st_idle;
						ack_q           <= sel_mem;  // dropped cycle gets no ack
						sram_pins.bhe_n <= 1'b1;
						sram_pins.ble_n <= 1'b1;
						sram_pins.we_n  <= 1'b1;
						sram_pins.oe_n  <= 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// write data is held for the whole access
	always_ff @(posedge clk) begin
		if (state == st_idle && start)
			sram_dq_out <= wb_req.dat;
	end

	// read sample on the ack edge, oe_n still low here
	always_ff @(posedge clk) begin
		if (state == st_access && cnt == cnt_w'(1))
			rdat_q <= wb_req.we ? 16'h0000 : sram_dq_in;
	end

	always_comb begin
		rsp.ack = ack_q;
		rsp.dat = ack_q ? rdat_q : 16'h0000;
	end

endmodule

/* logic/mm_cia_lite.sv */
// reduced cia-a on the low byte lane: port a, ddra, tod event counter, icr with flag
// no timers, no serial port, no alarm; clr returns ddra, latch and mask to reset values
`timescale 1ns/1ps

module mm_cia_lite (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            clr,
	input  logic            sel,
	input  mm_pkg::wb_req_t wb_req,
	input  logic [1:0]      fire_n,
	input  logic            flag_n,
	input  logic            tick,
	output mm_pkg::wb_rsp_t rsp,
	output logic            ovl,
	output logic            led_n,
	output logic            irq
);
	import mm_pkg::*;

	cpu_addr_u   a;
	logic [3:0]  rs;
	logic        acc, rd, wr;
	logic        ack_q;
	logic [7:0]  dat_q, rd_mux;
	logic [1:0]  pra_q;           // output latch, bits 1:0 only
	logic [7:0]  ddra_q;
	logic [1:0]  pa_out;
	logic [23:0] tod_cnt, tod_hold, tod_view;
	logic        tod_lat;
	logic        tick_q, flag_q;
	logic        flag_f;
	logic [4:0]  mask_q, flags;

	assign a   = wb_req.adr;
	assign rs  = a.f.cia_rs;
	assign acc = sel & ~ack_q;
	assign rd  = acc & ~wb_req.we;
	assign wr  = acc & wb_req.we & wb_req.sel[0];

	assign pa_out   = pra_q | ~ddra_q[1:0];  // inputs float high
	assign ovl      = pa_out[0];
	assign led_n    = pa_out[1];
	assign flags    = {flag_f, 4'b0000};     // only the flag source exists
	assign irq      = |(flags & mask_q);
	assign tod_view = tod_lat ? tod_hold : tod_cnt;

	// ------------------------------
	// register file
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q  <= 1'b0;
			pra_q  <= 2'b00;
			ddra_q <= 8'h00;
			mask_q <= 5'h00;
			flag_f <= 1'b0;
			flag_q <= 1'b1;
		end else if (clr) begin
			ack_q  <= 1'b0;
			pra_q  <= 2'b00;
			ddra_q <= 8'h00;   // all inputs, so ovl reads 1
			mask_q <= 5'h00;
			flag_f <= 1'b0;
			flag_q <= flag_n;
		end else begin
			ack_q  <= acc;
			flag_q <= flag_n;
			if (wr && rs == 4'h0)
				pra_q <= wb_req.dat[1:0];
			if (wr && rs == 4'h2)
				ddra_q <= wb_req.dat[7:0];
			if (wr && rs == 4'hd) begin
				if (wb_req.dat[7])
					mask_q <= mask_q | wb_req.dat[4:0];   // set
				else
					mask_q <= mask_q & ~wb_req.dat[4:0];  // clear
			end
			if (rd && rs == 4'hd)
				flag_f <= 1'b0;                          // read clears
			if (flag_q && !flag_n)
				flag_f <= 1'b1;                          // new edge wins
		end
	end

	// ------------------------------
	// time of day
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tod_cnt <= 24'h000000;
			tod_lat <= 1'b0;
			tick_q  <= 1'b0;
		end else begin
			tick_q <= tick;
			if (tick && !tick_q)
				tod_cnt <= tod_cnt + 24'd1;
			if (rd && rs == 4'ha)
				tod_lat <= 1'b1;   // high byte freezes the view
			else if (rd && rs == 4'h8)
				tod_lat <= 1'b0;   // low byte releases it
		end
	end

	always_ff @(posedge clk) begin
		if (rd && rs == 4'ha && !tod_lat)
			tod_hold <= tod_cnt;
	end

	// read path, registered with ack
	always_comb begin
		case (rs)
			4'h0:    rd_mux = {fire_n, 4'hf, pa_out};
			4'h2:    rd_mux = ddra_q;
			4'h8:    rd_mux = tod_view[7:0];
			4'h9:    rd_mux = tod_view[15:8];
			4'ha:    rd_mux = tod_view[23:16];
			4'hd:    rd_mux = {irq, 2'b00, flags};
			default: rd_mux = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		dat_q <= rd ? rd_mux : 8'h00;
	end

	always_comb begin
		rsp.ack = ack_q;
		rsp.dat = ack_q ? {8'h00, dat_q} : 16'h0000;  // high byte unused
	end

endmodule

/* logic/mm_sysctl.sv */
// reset stretch counted in frames, and the dimmed power led
// sof and hsync_n are expected synchronous to clk
`timescale 1ns/1ps
`include "mm_defines.svh"

module mm_sysctl (
	input  logic clk,
	input  logic rst_n,
	input  logic usr_rst,
	input  logic sof,
	input  logic hsync_n,
	input  logic led_n,
	output logic sys_reset,
	output logic pwr_led
);
	localparam int frm_w = $clog2(`MM_RESET_FRAMES + 1);
	localparam int led_w = $clog2(`MM_LED_DIM_LEN);

	logic             sof_q, hs_q;
	logic             sof_rise, hs_rise;
	logic [frm_w-1:0] frm_cnt;
	logic [led_w-1:0] led_cnt;
	logic             led_dim;

	assign sof_rise = sof & ~sof_q;
	assign hs_rise  = hsync_n & ~hs_q;

	// ------------------------------
	// reset stretcher
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sys_reset <= 1'b1;
			frm_cnt   <= '0;
			sof_q     <= 1'b0;
		end else begin
			sof_q <= sof;
			if (usr_rst) begin
				sys_reset <= 1'b1;   // restart the stretch
				frm_cnt   <= '0;
			end else if (sys_reset && sof_rise) begin
				if (frm_cnt == frm_w'(`MM_RESET_FRAMES - 1))
					sys_reset <= 1'b0;
				frm_cnt <= frm_cnt + 1'b1;
			end
		end
	end

	// ------------------------------
	// power led dimmer
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_cnt <= '0;
			led_dim <= 1'b0;
			hs_q    <= 1'b1;
		end else begin
			hs_q <= hsync_n;
			if (hs_rise) begin
				led_dim <= led_cnt == '0;  // one line lit per period
				if (led_cnt == led_w'(`MM_LED_DIM_LEN - 1))
					led_cnt <= '0;
				else
					led_cnt <= led_cnt + 1'b1;
			end
		end
	end

	assign pwr_led = ~led_n | led_dim;  // full on when driven low

endmodule

/* logic/mm_top.sv */
// bus core top: decode, shared sram, cia-a and system control
// single interrupt source, mapped to level 2 on the cpu ipl lines
`timescale 1ns/1ps
`include "mm_defines.svh"

module mm_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   usr_rst,
	input  mm_pkg::wb_req_t        wb_req,
	output mm_pkg::wb_rsp_t        wb_rsp,
	output mm_pkg::sram_pins_t     sram_pins,
	output logic [15:0]            sram_dq_out,
	input  logic [15:0]            sram_dq_in,
	input  logic [1:0]             fire_n,
	input  logic                   flag_n,
	input  logic                   tick,
	input  logic                   hsync_n,
	input  logic                   sof,
	input  logic [63:0]            rtc,
	output logic [2:0]             ipl_n,
	output logic                   cpu_reset_n,
	output logic                   pwr_led
);
	import mm_pkg::*;

	region_t                region;
	wb_rsp_t                dec_rsp, mem_rsp, cia_rsp;
	logic [`MM_SRAM_AW+1:1] sram_adr;
	logic                   rom_wp;
	logic                   ovl, led_n, irq;
	logic                   sys_reset;

	// ------------------------------
	// blocks
	// ------------------------------
	mm_bus_decode u_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_req   (wb_req),
		.ovl      (ovl),
		.rtc      (rtc),
		.region   (region),
		.sram_adr (sram_adr),
		.rom_wp   (rom_wp),
		.rsp      (dec_rsp)
	);

	mm_sram_bridge u_sram (
		.clk         (clk),
		.rst_n       (rst_n),
		.wb_req      (wb_req),
		.sel_mem     (region.chip | region.rom),
		.rom_wp      (rom_wp),
		.sram_adr    (sram_adr),
		.sram_pins   (sram_pins),
		.sram_dq_out (sram_dq_out),
		.sram_dq_in  (sram_dq_in),
		.rsp         (mem_rsp)
	);

	mm_cia_lite u_ciaa (
		.clk    (clk),
		.rst_n  (rst_n),
		.clr    (sys_reset),   // registers held at defaults during the stretch
		.sel    (region.cia),
		.wb_req (wb_req),
		.fire_n (fire_n),
		.flag_n (flag_n),
		.tick   (tick),
		.rsp    (cia_rsp),
		.ovl    (ovl),
		.led_n  (led_n),
		.irq    (irq)
	);

	mm_sysctl u_sysctl (
		.clk       (clk),
		.rst_n     (rst_n),
		.usr_rst   (usr_rst),
		.sof       (sof),
		.hsync_n   (hsync_n),
		.led_n     (led_n),
		.sys_reset (sys_reset),
		.pwr_led   (pwr_led)
	);

	// responders are zero when idle, so a plain or is enough
	assign wb_rsp.ack = dec_rsp.ack | mem_rsp.ack | cia_rsp.ack;
	assign wb_rsp.dat = dec_rsp.dat | mem_rsp.dat | cia_rsp.dat;

	assign ipl_n       = irq ? 3'b101 : 3'b111;  // level 2
	assign cpu_reset_n = ~sys_reset;

endmodule

/* testbench/tb_mm_top.sv */
// self-checking testbench for mm_top, sram model of 2^20 words behind the pins
// rom half filled from $random with a fixed seed, chip half zeroed
// stops at the first mismatch or timeout
`timescale 1ns/1ps
`include "mm_defines.svh"

module tb_mm_top;
	import mm_pkg::*;

	localparam int ack_limit = 16;          // edges allowed per bus cycle
	localparam int run_limit = 16;          // edges allowed for reset release
	localparam logic [63:0] rtc_val = 64'h0F1E_2D3C_4B5A_6978;
	localparam logic [23:0] tod_n   = 24'h010105;  // every byte nonzero
	localparam int          tod_more = 5;
	localparam logic [23:0] tod_sum = tod_n + 24'(tod_more);
	localparam int          led_periods = 32;

	// cia-a registers, rs in address bits 11:8
	localparam logic [23:0] pra_a     = 24'hBFE001;
	localparam logic [23:0] ddra_a    = 24'hBFE201;
	localparam logic [23:0] tod_lo_a  = 24'hBFE801;
	localparam logic [23:0] tod_mid_a = 24'hBFE901;
	localparam logic [23:0] tod_hi_a  = 24'hBFEA01;
	localparam logic [23:0] icr_a     = 24'hBFED01;

	// one table entry
	typedef struct packed {
		logic        we;
		logic [23:0] adr;    // byte address
		logic [1:0]  sel;
		logic [15:0] wdat;
		logic [15:0] rdat;   // expected read data
		logic        chk;
	} step_t;

	logic         clk = 1'b0;
	logic         rst_n, usr_rst;
	wb_req_t      wb_req;
	wb_rsp_t      wb_rsp;
	sram_pins_t   sram_pins;
	logic [15:0]  sram_dq_out, sram_dq_in;
	logic [1:0]   fire_n;
	logic         flag_n, tick, hsync_n, sof;
	logic [63:0]  rtc;
	logic [2:0]   ipl_n;
	logic         cpu_reset_n, pwr_led;

	logic [15:0]  sram_mem [0:(1<<20)-1];
	logic [15:0]  rom_ref [0:15];          // copy of the first rom words
	step_t        steps [$];

	always #5 clk = ~clk;

	mm_top uut (.*);  // tb names match the port names

	// ------------------------------
	// sram model
	// ------------------------------
	assign sram_dq_in = sram_pins.oe_n ? 16'h0000 : sram_mem[sram_pins.adr];

	always @(posedge clk) begin
		if (rst_n && !sram_pins.we_n) begin
			if (!sram_pins.bhe_n)
				sram_mem[sram_pins.adr][15:8] <= sram_dq_out[15:8];
			if (!sram_pins.ble_n)
				sram_mem[sram_pins.adr][7:0] <= sram_dq_out[7:0];
		end
	end

	// rom bank must never see a write strobe
	always @(negedge clk) begin
		if (rst_n && !sram_pins.we_n)
			check("sram_pins.adr[20] on write", 64'(sram_pins.adr[20]), 64'h0);
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got %0h expected %0h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic expect_read(input logic [23:0] adr, input logic [15:0] exp);
		step_t s;
		s      = '0;
		s.adr  = adr;
		s.sel  = 2'b11;
		s.rdat = exp;
		s.chk  = 1'b1;
		steps.push_back(s);
	endtask

	task automatic post_write(input logic [23:0] adr, input logic [1:0] sel,
		input logic [15:0] wdat);
		step_t s;
		s      = '0;
		s.we   = 1'b1;
		s.adr  = adr;
		s.sel  = sel;
		s.wdat = wdat;
		steps.push_back(s);
	endtask

	// one wishbone classic cycle, ack sampled mid-cycle
	task automatic bus_cycle(input step_t s, output logic [15:0] rdat);
		wb_req_t r;
		int      n;
		r     = '0;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.we  = s.we;
		r.sel = s.sel;
		r.adr = s.adr[23:1];
		r.dat = s.wdat;
		@(posedge clk);
		wb_req <= r;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > ack_limit) begin
				$display("no ack from the bus core for address %h", s.adr);
				$display("TEST FAILED");
				$fatal(1, "ack timeout");
			end
		end while (!wb_rsp.ack);
		rdat = wb_rsp.dat;
		@(posedge clk);
		wb_req <= '0;   // stb low for at least one cycle
	endtask

	// apply and empty the table
	task automatic run_steps();
		step_t       s;
		logic [15:0] rdat;
		while (steps.size() > 0) begin
			s = steps.pop_front();
			bus_cycle(s, rdat);
			if (s.chk)
				check($sformatf("wb_rsp.dat at %h", s.adr), 64'(rdat), 64'(s.rdat));
		end
	endtask

	task automatic sof_pulses(input int n);
		repeat (n) begin
			@(posedge clk);
			sof <= 1'b1;
			@(posedge clk);
			sof <= 1'b0;
			@(posedge clk);   // frame gap
		end
	endtask

	task automatic tick_pulses(input int n);
		repeat (n) begin
			@(posedge clk);
			tick <= 1'b1;
			@(posedge clk);
			tick <= 1'b0;
			@(posedge clk);
		end
	endtask

	task automatic flag_edges(input int n);
		repeat (n) begin
			@(posedge clk);
			flag_n <= 1'b0;   // falling edge sets the flag
			@(posedge clk);
			flag_n <= 1'b1;
			@(posedge clk);
		end
	endtask

	// hsync periods, pwr_led sampled once after each rising edge
	task automatic count_led(input int periods, output int lit);
		lit = 0;
		repeat (periods) begin
			@(posedge clk);
			hsync_n <= 1'b0;
			@(posedge clk);
			hsync_n <= 1'b1;
			@(posedge clk);
			@(negedge clk);
			if (pwr_led)
				lit++;
		end
	endtask

	task automatic wait_cpu_run();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > run_limit) begin
				$display("cpu_reset_n did not release after the last frame");
				$display("TEST FAILED");
				$fatal(1, "reset timeout");
			end
		end while (cpu_reset_n !== 1'b1);
	endtask

	// low through all but the last frame, then released
	task automatic reset_stretch();
		sof_pulses(`MM_RESET_FRAMES - 1);
		@(negedge clk);
		check("cpu_reset_n", 64'(cpu_reset_n), 64'h0);
		sof_pulses(1);
		wait_cpu_run();
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin : main
		integer      seed;
		logic [19:0] wa;
		int          lit;
		rst_n   = 1'b0;
		usr_rst = 1'b0;
		wb_req  = '0;
		fire_n  = 2'b10;
		flag_n  = 1'b1;
		tick    = 1'b0;
		hsync_n = 1'b1;
		sof     = 1'b0;
		rtc     = rtc_val;

		seed = 32'h197d;
		for (int i = 0; i < (1 << 19); i++) begin
			wa = 20'(i);
			sram_mem[wa] = 16'h0000;                            // chip half
			sram_mem[{1'b1, wa[18:0]}] = 16'($random(seed));  // rom half
		end
		for (int i = 0; i < 16; i++)
			rom_ref[i] = sram_mem[{1'b1, 19'(i)}];

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check("cpu_reset_n", 64'(cpu_reset_n), 64'h0);
		check("sram_pins.oe_n", 64'(sram_pins.oe_n), 64'h1);
		check("sram_pins.we_n", 64'(sram_pins.we_n), 64'h1);
		check("sram_pins.bhe_n", 64'(sram_pins.bhe_n), 64'h1);
		check("sram_pins.ble_n", 64'(sram_pins.ble_n), 64'h1);
		check("wb_rsp.ack", 64'(wb_rsp.ack), 64'h0);

		// reset stretch, then again from a user reset
		reset_stretch();
		@(posedge clk);
		usr_rst <= 1'b1;
		@(posedge clk);
		usr_rst <= 1'b0;
		@(negedge clk);
		check("cpu_reset_n", 64'(cpu_reset_n), 64'h0);
		reset_stretch();

		// overlay on, then cleared through port a
		expect_read(24'h000000, rom_ref[0]);
		expect_read(24'h000002, rom_ref[1]);
		post_write(ddra_a, 2'b01, 16'h0003);
		post_write(pra_a, 2'b01, 16'h0000);
		expect_read(ddra_a, 16'h0003);
		expect_read(pra_a, 16'h00BC);        // fire_n 10, spare bits high, latch 00
		expect_read(24'h000000, 16'h0000);   // chip ram now
		expect_read(24'hF80000, rom_ref[0]);
		run_steps();

		// chip ram lanes, rom write protect
		post_write(24'h001000, 2'b11, 16'h1234);
		expect_read(24'h001000, 16'h1234);
		post_write(24'h001000, 2'b10, 16'hABCD);
		expect_read(24'h001000, 16'hAB34);   // upper lane only
		post_write(24'h001000, 2'b01, 16'h55EE);
		expect_read(24'h001000, 16'hABEE);   // lower lane only
		expect_read(24'h001002, 16'h0000);
		post_write(24'h07FFFE, 2'b11, 16'hC0DE);
		expect_read(24'h07FFFE, 16'hC0DE);
		post_write(24'hF80010, 2'b11, 16'hDEAD);
		expect_read(24'hF80010, rom_ref[8]);
		run_steps();

		// flag with mask clear, no interrupt
		flag_edges(2);
		@(negedge clk);
		check("ipl_n", 64'(ipl_n), 64'(3'b111));
		expect_read(icr_a, 16'h0010);
		expect_read(icr_a, 16'h0000);        // cleared by the read
		post_write(icr_a, 2'b01, 16'h0090);  // set flag mask
		run_steps();
		flag_edges(1);
		@(negedge clk);
		check("ipl_n", 64'(ipl_n), 64'(3'b101));
		expect_read(icr_a, 16'h0090);
		run_steps();
		@(negedge clk);
		check("ipl_n", 64'(ipl_n), 64'(3'b111));

		// tod, high byte latches until the low byte is read
		tick_pulses(int'(tod_n));
		expect_read(tod_hi_a, 16'(tod_n[23:16]));
		run_steps();
		tick_pulses(tod_more);
		expect_read(tod_mid_a, 16'(tod_n[15:8]));
		expect_read(tod_lo_a, 16'(tod_n[7:0]));
		expect_read(tod_lo_a, 16'(tod_sum[7:0]));  // live count again
		run_steps();

		// rtc nibbles by address bits 5:2, unmapped space
		for (int k = 0; k < 16; k++)
			expect_read(24'hDC0000 | 24'(k << 2), 16'((rtc_val >> (4 * k)) & 64'hf));
		expect_read(24'h400000, 16'h0000);
		post_write(24'h600000, 2'b11, 16'h5A5A);
		run_steps();

		// led dimmed with led_n high, full on with led_n low
		post_write(pra_a, 2'b01, 16'h0002);
		run_steps();
		count_led(led_periods, lit);
		check("pwr_led lit periods", 64'(lit), 64'(2));
		post_write(pra_a, 2'b01, 16'h0000);
		run_steps();
		count_led(led_periods, lit);
		check("pwr_led lit periods", 64'(lit), 64'(led_periods));

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+logic
logic/mm_pkg.sv
logic/mm_bus_decode.sv
logic/mm_sram_bridge.sv
logic/mm_cia_lite.sv
logic/mm_sysctl.sv
logic/mm_top.sv
testbench/tb_mm_top.sv

/* Makefile */
TOP := tb_mm_top

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f logic/*.sv logic/*.svh testbench/*.sv
	verilator --binary --timing -f sim.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
